// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = tb_manycore_boot
FLIST = list.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, exit status is the result"
	@echo "  clean  remove obj_dir"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== list.f ====
verilog/mc_packet_pkg.sv
verilog/mc_boot_pkg.sv
verilog/wb_arbiter.sv
verilog/program_mem.sv
verilog/spmd_loader.sv
verilog/finish_monitor.sv
verilog/manycore_boot.sv
sim/tb_manycore_boot.sv

// ==== sim/tb_manycore_boot.sv ====
`timescale 1ns/1ps

module tb_manycore_boot;

  import mc_boot_pkg::*;
  import mc_packet_pkg::*;

  localparam int words_p = 64;
  localparam int tiles_x = 2;
  localparam int tiles_y = 2;
  localparam int ntiles  = tiles_x * tiles_y;

  logic        clk_i;
  logic        rst_i;
  wb_req_t     host_req_i;
  wb_rsp_t     host_rsp_o;
  logic        start_i;
  logic [6:0]  load_words_i;
  logic        busy_o;
  mc_packet_t  pkt_o;
  logic        pkt_v_o;
  logic        pkt_ready_i;
  mc_packet_t  ret_pkt_i;
  logic        ret_v_i;
  logic        finish_o;
  logic        fail_o;
  logic [31:0] code_o;
  logic        timeout_o;

  int          seed;
  logic [31:0] image [words_p]; // what the host wrote

  manycore_boot
    #(.mem_words_p   (words_p)
      , .num_tiles_x_p (tiles_x)
      , .num_tiles_y_p (tiles_y)
      , .max_cycles_p  (300))
    i_dut (.*);

  always #10 clk_i = ~clk_i;

  // drive point, just after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("[FAIL] %s actual %h expected %h", name, actual, expected);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  task automatic reset_dut();
    tick();
    rst_i = 1'b1;
    repeat (16) tick();
    rst_i = 1'b0;
    @(negedge clk_i);
    check_equal("busy_o", 32'(busy_o), 32'h0);
    check_equal("pkt_v_o", 32'(pkt_v_o), 32'h0);
    check_equal("host_rsp_o.ack", 32'(host_rsp_o.ack), 32'h0);
    check_equal("finish_o", 32'(finish_o), 32'h0);
    check_equal("fail_o", 32'(fail_o), 32'h0);
    check_equal("timeout_o", 32'(timeout_o), 32'h0);
  endtask

  // one wishbone classic cycle from the host side
  task automatic host_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n = 0;
    tick();
    host_req_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(negedge clk_i);
    while (!host_rsp_o.ack)
    begin
      n++;
      if (n > 40)
      begin
        $display("host access at address %h got no ack", adr);
        $display("RESULT: FAIL");
        $fatal(1);
      end
      @(negedge clk_i);
    end
    rdat = host_rsp_o.dat;
    tick();
    host_req_i = '0; // drop cyc after ack
  endtask

  // k-th packet of a boot, stores tile by tile then unfreezes
  function automatic mc_packet_t expected_packet(input int k, input int nwords);
    mc_packet_t p;
    int         tile;
    int         word;
    p = '0;
    if (k < ntiles * nwords)
    begin
      tile   = k / nwords;
      word   = k % nwords;
      p.op   = op_store;
      p.addr = 32'(4 * word);
      p.data = image[word];
    end
    else
    begin
      tile   = k - ntiles * nwords;
      p.op   = op_config;
      p.addr = freeze_addr;
      p.data = 32'h0;
    end
    p.x_cord = x_cord_width'(tile % tiles_x);
    p.y_cord = y_cord_width'(tile / tiles_x);
    return p;
  endfunction

  // called at a sample point
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o)
    begin
      n++;
      if (n > 20)
      begin
        $display("busy_o stayed high after the last packet");
        $display("RESULT: FAIL");
        $fatal(1);
      end
      @(negedge clk_i);
    end
    check_equal("pkt_v_o", 32'(pkt_v_o), 32'h0);
  endtask

  task automatic run_boot(input int nwords, input bit random_ready);
    int          k;
    int          n;
    int          total;
    logic [31:0] rnd;
    mc_packet_t  exp_pkt;
    total = ntiles * nwords + ntiles;
    k = 0;
    n = 0;
    tick();
    start_i      = 1'b1;
    load_words_i = 7'(nwords);
    tick();
    start_i      = 1'b0;
    pkt_ready_i  = 1'b1;
    @(negedge clk_i);
    check_equal("busy_o", 32'(busy_o), 32'h1);
    while (k < total)
    begin
      if (pkt_v_o && pkt_ready_i)
      begin
        exp_pkt = expected_packet(k, nwords);
        check_equal("pkt_o.op", 32'(pkt_o.op), 32'(exp_pkt.op));
        check_equal("pkt_o.addr", pkt_o.addr, exp_pkt.addr);
        check_equal("pkt_o.data", pkt_o.data, exp_pkt.data);
        check_equal("pkt_o.x_cord", 32'(pkt_o.x_cord), 32'(exp_pkt.x_cord));
        check_equal("pkt_o.y_cord", 32'(pkt_o.y_cord), 32'(exp_pkt.y_cord));
        k++;
        n = 0;
      end
      else
      begin
        n++;
        if (n > 100)
        begin
          $display("packet %0d of the boot never arrived", k);
          $display("RESULT: FAIL");
          $fatal(1);
        end
      end
      tick();
      if (random_ready)
      begin
        rnd = $random(seed);
        pkt_ready_i = rnd[0];
      end
      @(negedge clk_i);
    end
    wait_idle();
  endtask

  task automatic wait_flag(input int which, input int limit);
    int   n;
    logic flag;
    n = 0;
    flag = (which == 0) ? finish_o : (which == 1) ? fail_o : timeout_o;
    while (!flag)
    begin
      n++;
      if (n > limit)
      begin
        $display("status flag %0d did not rise within %0d cycles", which, limit);
        $display("RESULT: FAIL");
        $fatal(1);
      end
      @(negedge clk_i);
      flag = (which == 0) ? finish_o : (which == 1) ? fail_o : timeout_o;
    end
  endtask

  task automatic send_return(input logic [31:0] addr, input logic [31:0] code);
    tick();
    ret_pkt_i      = '0;
    ret_pkt_i.op   = op_store;
    ret_pkt_i.addr = addr;
    ret_pkt_i.data = code;
    ret_v_i        = 1'b1;
    tick();
    ret_v_i        = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic host_bus_rw();
    logic [31:0] rdat;
    for (int i = 0; i < 16; i++)
    begin
      image[i] = $random(seed);
      host_access(1'b1, 32'(4 * i), image[i], rdat);
    end
    for (int i = 0; i < 16; i++)
    begin
      host_access(1'b0, 32'(4 * i), 32'h0, rdat);
      check_equal("host_rsp_o.dat", rdat, image[i]);
    end
  endtask

  task automatic open_sink_boot();
    run_boot(16, 1'b0);
  endtask

  task automatic backpressure_boot();
    run_boot(16, 1'b1);
  endtask

  task automatic contention_boot();
    logic [31:0] rdat;
    int          n;
    fork
      run_boot(16, 1'b0);
      begin
        n = 0;
        @(negedge clk_i);
        while (!busy_o)
        begin
          n++;
          if (n > 10)
          begin
            $display("busy_o never rose for the contention boot");
            $display("RESULT: FAIL");
            $fatal(1);
          end
          @(negedge clk_i);
        end
        // words past the loaded image
        for (int i = 40; i < 48; i++)
        begin
          image[i] = $random(seed);
          host_access(1'b1, 32'(4 * i), image[i], rdat);
          host_access(1'b0, 32'(4 * i), 32'h0, rdat);
          check_equal("host_rsp_o.dat", rdat, image[i]);
        end
        @(negedge clk_i);
        check_equal("busy_o", 32'(busy_o), 32'h1);
      end
    join
  endtask

  task automatic finish_fail_status();
    logic [31:0] code;
    reset_dut();
    code = $random(seed);
    send_return(finish_addr, code);
    wait_flag(0, 10);
    check_equal("code_o", code_o, code);
    check_equal("fail_o", 32'(fail_o), 32'h0);
    reset_dut();
    code = $random(seed);
    send_return(fail_addr, code);
    wait_flag(1, 10);
    check_equal("code_o", code_o, code);
    check_equal("finish_o", 32'(finish_o), 32'h0);
  endtask

  task automatic idle_timeout();
    reset_dut();
    run_boot(0, 1'b0); // unfreeze packets only
    wait_flag(2, 400);
    check_equal("finish_o", 32'(finish_o), 32'h0);
    check_equal("fail_o", 32'(fail_o), 32'h0);
  endtask

  initial
  begin
    seed         = 32'h008ccf30;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    host_req_i   = '0;
    start_i      = 1'b0;
    load_words_i = '0;
    pkt_ready_i  = 1'b0;
    ret_pkt_i    = '0;
    ret_v_i      = 1'b0;
    reset_dut();
    host_bus_rw();
    open_sink_boot();
    backpressure_boot();
    contention_boot();
    finish_fail_status();
    idle_timeout();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== verilog/finish_monitor.sv ====
`timescale 1ns/1ps

module finish_monitor
  #(parameter int max_cycles_p = 100000)
  (input                              clk_i
   , input                            rst_i
   , input                            busy_i
   , input mc_packet_pkg::mc_packet_t ret_pkt_i
   , input                            ret_v_i
   , output logic                     finish_o
   , output logic                     fail_o
   , output logic [31:0]              code_o
   , output logic                     timeout_o
  );

  import mc_packet_pkg::*;

  localparam int cnt_w = $clog2(max_cycles_p + 1);

  logic             hit_finish;
  logic             hit_fail;
  logic             booted_q; // a boot has started since reset
  logic             run;
  logic [cnt_w-1:0] cnt_q;

  assign hit_finish = ret_v_i && ret_pkt_i.op == op_store && ret_pkt_i.addr == finish_addr;
  assign hit_fail   = ret_v_i && ret_pkt_i.op == op_store && ret_pkt_i.addr == fail_addr;

  assign run = booted_q & ~busy_i & ~finish_o & ~fail_o & ~timeout_o;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      finish_o  <= 1'b0;
      fail_o    <= 1'b0;
      timeout_o <= 1'b0;
      booted_q  <= 1'b0;
      cnt_q     <= '0;
    end
    else
    begin
      finish_o <= finish_o | hit_finish; // sticky
      fail_o   <= fail_o | hit_fail;
      if (busy_i)
      begin
        booted_q <= 1'b1;
        cnt_q    <= '0; // restart on every boot
      end
      else if (run)
      begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q == cnt_w'(max_cycles_p - 1))
        begin
          timeout_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (hit_finish || hit_fail)
    begin
      code_o <= ret_pkt_i.data;
    end
  end

  a_one_status: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(finish_o) |-> !$rose(fail_o));

endmodule

// ==== verilog/manycore_boot.sv ====
`timescale 1ns/1ps

module manycore_boot
  #(parameter int mem_words_p   = 256
    , parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2
    , parameter int max_cycles_p  = 100000)
  (input                               clk_i
   , input                             rst_i
   , input  mc_boot_pkg::wb_req_t      host_req_i
   , output mc_boot_pkg::wb_rsp_t      host_rsp_o
   , input                             start_i
   , input  [$clog2(mem_words_p):0]    load_words_i
   , output logic                      busy_o
   , output mc_packet_pkg::mc_packet_t pkt_o
   , output logic                      pkt_v_o
   , input                             pkt_ready_i
   , input  mc_packet_pkg::mc_packet_t ret_pkt_i
   , input                             ret_v_i
   , output logic                      finish_o
   , output logic                      fail_o
   , output logic [31:0]               code_o
   , output logic                      timeout_o
  );

  import mc_boot_pkg::*;

  wb_req_t ldr_req;
  wb_rsp_t ldr_rsp;
  wb_req_t mem_req;
  wb_rsp_t mem_rsp;

  wb_arbiter i_arbiter
    (.clk_i, .rst_i
     , .host_req_i, .host_rsp_o
     , .ldr_req_i (ldr_req), .ldr_rsp_o (ldr_rsp)
     , .mem_req_o (mem_req), .mem_rsp_i (mem_rsp));

  program_mem #(.mem_words_p(mem_words_p)) i_mem
    (.clk_i, .rst_i, .req_i (mem_req), .rsp_o (mem_rsp));

  spmd_loader
    #(.mem_words_p   (mem_words_p)
      , .num_tiles_x_p (num_tiles_x_p)
      , .num_tiles_y_p (num_tiles_y_p))
    i_loader
    (.clk_i, .rst_i
     , .start_i, .load_words_i, .busy_o
     , .wb_req_o (ldr_req), .wb_rsp_i (ldr_rsp)
     , .pkt_o, .pkt_v_o, .pkt_ready_i);

  // monitor times out relative to the end of boot
  finish_monitor #(.max_cycles_p(max_cycles_p)) i_monitor
    (.clk_i, .rst_i
     , .busy_i (busy_o)
     , .ret_pkt_i, .ret_v_i
     , .finish_o, .fail_o, .code_o, .timeout_o);

endmodule

// ==== verilog/mc_boot_pkg.sv ====
package mc_boot_pkg;

  // wishbone classic master request, whole words only
  typedef struct packed
  {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr; // byte address
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed
  {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // loader FSM
  typedef enum logic [2:0]
  {
    st_idle,
    st_read,
    st_send,
    st_unfreeze,
    st_done
  } loader_state_e;

endpackage

// ==== verilog/mc_packet_pkg.sv ====
package mc_packet_pkg;

  localparam int x_cord_width = 2;
  localparam int y_cord_width = 2;

  // network opcodes seen by the tiles
  typedef enum logic [1:0]
  {
    op_store  = 2'd1, // data store into tile memory
    op_config = 2'd2  // store to tile freeze register
  } mc_op_e;

  // 70 bits, op in the top bits
  typedef struct packed
  {
    mc_op_e                  op;
    logic [31:0]             addr;
    logic [31:0]             data;
    logic [x_cord_width-1:0] x_cord;
    logic [y_cord_width-1:0] y_cord;
  } mc_packet_t;

  // byte addresses agreed between tile programs and the monitor
  localparam logic [31:0] finish_addr = 32'h0000_eadc;
  localparam logic [31:0] fail_addr   = 32'h0000_eae0;

  // freeze register inside each tile
  localparam logic [31:0] freeze_addr = 32'h0000_0800;

endpackage

// ==== verilog/program_mem.sv ====
`timescale 1ns/1ps

module program_mem
  #(parameter int mem_words_p = 256)
  (input                         clk_i
   , input                       rst_i
   , input  mc_boot_pkg::wb_req_t req_i
   , output mc_boot_pkg::wb_rsp_t rsp_o
  );

  localparam int idx_w = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  logic [31:0]      mem_q [mem_words_p];
  logic [31:0]      rdata_q;
  logic             ack_q;
  logic             access;
  logic [idx_w-1:0] word_idx;

  // one access per request, not repeated while ack is up
  assign access   = req_i.cyc & req_i.stb & ~ack_q;
  assign word_idx = idx_w'((req_i.adr >> 2) % mem_words_p);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      ack_q <= 1'b0;
    end
    else
    begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (access)
    begin
      if (req_i.we)
      begin
        mem_q[word_idx] <= req_i.dat;
      end
      rdata_q <= mem_q[word_idx]; // old contents on a write
    end
  end

  assign rsp_o = '{ack: ack_q, dat: rdata_q};

  // master must still hold its request through the arbiter
  a_ack_with_req: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_q |-> req_i.cyc && req_i.stb);

endmodule

// ==== verilog/spmd_loader.sv ====
`timescale 1ns/1ps

module spmd_loader
  #(parameter int mem_words_p   = 256
    , parameter int num_tiles_x_p = 2
    , parameter int num_tiles_y_p = 2)
  (input                               clk_i
   , input                             rst_i
   , input                             start_i
   , input  [$clog2(mem_words_p):0]    load_words_i
   , output logic                      busy_o
   , output mc_boot_pkg::wb_req_t      wb_req_o
   , input  mc_boot_pkg::wb_rsp_t      wb_rsp_i
   , output mc_packet_pkg::mc_packet_t pkt_o
   , output logic                      pkt_v_o
   , input                             pkt_ready_i
  );

  import mc_boot_pkg::*;
  import mc_packet_pkg::*;

  localparam int lw_w = $clog2(mem_words_p) + 1;

  localparam logic [x_cord_width-1:0] last_x = x_cord_width'(num_tiles_x_p - 1);
  localparam logic [y_cord_width-1:0] last_y = y_cord_width'(num_tiles_y_p - 1);

  loader_state_e           state_q;
  logic [lw_w-1:0]         word_q;
  logic [lw_w-1:0]         nwords_q;
  logic [31:0]             data_q;
  logic [x_cord_width-1:0] tile_x_q;
  logic [y_cord_width-1:0] tile_y_q;
  logic                    last_tile;
  logic                    last_word;
  logic                    xfer;

  assign last_tile = (tile_x_q == last_x) && (tile_y_q == last_y);
  assign last_word = (word_q == nwords_q - lw_w'(1));
  assign xfer      = pkt_v_o & pkt_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= st_idle;
      word_q   <= '0;
      tile_x_q <= '0;
      tile_y_q <= '0;
    end
    else
    begin
      case (state_q)
        st_idle, st_done:
        begin
          state_q <= st_idle;
          if (start_i)
          begin
            word_q   <= '0;
            tile_x_q <= '0;
            tile_y_q <= '0;
            nwords_q <= load_words_i;
            state_q  <= (load_words_i == '0) ? st_unfreeze : st_read;
          end
        end
        st_read:
        begin
          if (wb_rsp_i.ack)
          begin
            data_q  <= wb_rsp_i.dat;
            state_q <= st_send;
          end
        end
        st_send:
        begin
          if (xfer)
          begin
            state_q <= st_read;
            word_q  <= word_q + lw_w'(1);
            if (last_word)
            begin
              word_q <= '0;
              if (last_tile)
              begin
                state_q <= st_unfreeze;
              end
            end
          end
        end
        st_unfreeze:
        begin
          if (xfer && last_tile)
          begin
            state_q <= st_done;
          end
        end
        default: state_q <= st_idle;
      endcase

      // row-major tile walk, wraps to 0,0 after the last tile
      if (xfer && ((state_q == st_send && last_word) || state_q == st_unfreeze))
      begin
        if (tile_x_q == last_x)
        begin
          tile_x_q <= '0;
          tile_y_q <= last_tile ? '0 : tile_y_q + 1'b1;
        end
        else
        begin
          tile_x_q <= tile_x_q + 1'b1;
        end
      end
    end
  end

  assign busy_o  = (state_q == st_read) || (state_q == st_send) || (state_q == st_unfreeze);
  assign pkt_v_o = (state_q == st_send) || (state_q == st_unfreeze);

  always_comb
  begin
    wb_req_o     = '0;
    wb_req_o.cyc = (state_q == st_read);
    wb_req_o.stb = (state_q == st_read);
    wb_req_o.adr = 32'(word_q) << 2;
  end

  always_comb
  begin
    pkt_o        = '0;
    pkt_o.x_cord = tile_x_q;
    pkt_o.y_cord = tile_y_q;
    if (state_q == st_unfreeze)
    begin
      pkt_o.op   = op_config;
      pkt_o.addr = freeze_addr;
      pkt_o.data = 32'h0; // clear freeze
    end
    else
    begin
      pkt_o.op   = op_store;
      pkt_o.addr = 32'(word_q) << 2;
      pkt_o.data = data_q;
    end
  end

  // stalled packet is held until the sink takes it
  a_pkt_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    pkt_v_o && !pkt_ready_i |=> pkt_v_o && $stable(pkt_o));

endmodule

// ==== verilog/wb_arbiter.sv ====
`timescale 1ns/1ps

module wb_arbiter
  (input                         clk_i
   , input                       rst_i
   , input  mc_boot_pkg::wb_req_t host_req_i
   , output mc_boot_pkg::wb_rsp_t host_rsp_o
   , input  mc_boot_pkg::wb_req_t ldr_req_i
   , output mc_boot_pkg::wb_rsp_t ldr_rsp_o
   , output mc_boot_pkg::wb_req_t mem_req_o
   , input  mc_boot_pkg::wb_rsp_t mem_rsp_i
  );

  logic gnt_q;     // 0 host, 1 loader
  logic lock_q;    // owner held cyc last cycle
  logic owner_cyc;
  logic sel;

  assign owner_cyc = gnt_q ? ldr_req_i.cyc : host_req_i.cyc;

  always_comb
  begin
    if (lock_q && owner_cyc)
    begin
      sel = gnt_q;
    end
    else
    begin
      sel = ~host_req_i.cyc & ldr_req_i.cyc; // host wins a tie
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      gnt_q  <= 1'b0;
      lock_q <= 1'b0;
    end
    else
    begin
      gnt_q  <= sel;
      lock_q <= sel ? ldr_req_i.cyc : host_req_i.cyc;
    end
  end

  assign mem_req_o = sel ? ldr_req_i : host_req_i;

  // only the owner sees ack
  assign host_rsp_o = '{ack: mem_rsp_i.ack & ~sel, dat: mem_rsp_i.dat};
  assign ldr_rsp_o  = '{ack: mem_rsp_i.ack & sel, dat: mem_rsp_i.dat};

  // a master keeps the bus for its whole cycle
  a_grant_locked: assert property (@(posedge clk_i) disable iff (rst_i)
    !$past(rst_i) && $past(sel ? ldr_req_i.cyc : host_req_i.cyc)
      && ($past(sel) ? ldr_req_i.cyc : host_req_i.cyc) |-> sel == $past(sel));

endmodule
